//--- branch_types_pkg.sv
package branch_types_pkg;

  // Data and address width of the core
  parameter int OPERAND_WIDTH = 32;

  // Fixed instruction word width
  parameter int INSN_WIDTH = 32;

  // Major opcode field width
  parameter int OPCODE_WIDTH = 6;

  // Number of exception vector slots, index width
  parameter int VEC_SEL_WIDTH = 2;

  // Instruction address, PC or branch target
  typedef logic [OPERAND_WIDTH-1:0] addr_t;

  // Raw instruction word from decode
  typedef logic [INSN_WIDTH-1:0] insn_t;

  // Major opcode, top bits of the word
  typedef logic [OPCODE_WIDTH-1:0] opcode_t;

  // Vector register index
  typedef logic [VEC_SEL_WIDTH-1:0] vec_sel_t;

endpackage

//--- branch_isa_pkg.sv
package branch_isa_pkg;

  import branch_types_pkg::*;

  // Opcode field sits in bits 31..26
  parameter int OPC_LSB = 26;

  // Immediate offset field, word offset in bits 25..0
  parameter int BRANCH_OFF_W = 26;

  // Unconditional PC-relative jump
  parameter opcode_t OPC_J = 6'h00;

  // Branch if flag clear
  parameter opcode_t OPC_BNF = 6'h03;

  // Branch if flag set
  parameter opcode_t OPC_BF = 6'h04;

  // Jump to register operand B
  parameter opcode_t OPC_JR = 6'h11;

  // Exception causes, value doubles as vector slot
  typedef enum logic [1:0] {
    EXC_NONE    = 2'd0,
    EXC_SYSCALL = 2'd1,
    EXC_ALIGN   = 2'd2,
    EXC_ILLEGAL = 2'd3
  } exc_cause_e;

endpackage

//--- branch_decode.sv
module branch_decode
  import branch_types_pkg::*;
  import branch_isa_pkg::*;
#(
  parameter int OPERAND_WIDTH = branch_types_pkg::OPERAND_WIDTH
) (
  // Instruction in decode and its address
  input  insn_t decode_insn_i,
  input  addr_t decode_pc_i,

  // Flag from control stage
  input  logic  ctrl_flag_i,

  // Taken immediate branch, register jump, immediate target
  output logic  dec_branch_o,
  output logic  dec_jr_o,
  output addr_t dec_target_o
);

  // Number of sign bits above the shifted offset
  localparam int EXT_W = OPERAND_WIDTH - BRANCH_OFF_W - 2;

  opcode_t                  opcode;
  logic [BRANCH_OFF_W-1:0]  branch_off;
  logic [OPERAND_WIDTH-1:0] off_ext;

  // Field extraction
  assign opcode     = decode_insn_i[OPC_LSB +: $bits(opcode_t)];
  assign branch_off = decode_insn_i[BRANCH_OFF_W-1:0];

  // Word offset to byte offset, sign extended
  assign off_ext = {{EXT_W{branch_off[BRANCH_OFF_W-1]}}, branch_off, 2'b00};

  // PC-relative target, only meaningful for immediate branches
  assign dec_target_o = decode_pc_i + off_ext;

  // Branch kind
  always_comb begin
    dec_branch_o = 1'b0;
    dec_jr_o     = 1'b0;
    case (opcode)
      OPC_J: begin
        // Always taken
        dec_branch_o = 1'b1;
      end
      OPC_BF: begin
        // Taken on flag set
        dec_branch_o = ctrl_flag_i;
      end
      OPC_BNF: begin
        // Taken on flag clear
        dec_branch_o = ~ctrl_flag_i;
      end
      OPC_JR: begin
        // Target comes later from the register file
        dec_jr_o = 1'b1;
      end
      default: begin
        // Not a branch
        dec_branch_o = 1'b0;
        dec_jr_o     = 1'b0;
      end
    endcase
  end

endmodule

//--- except_vector_regs.sv
module except_vector_regs
  import branch_types_pkg::*;
  import branch_isa_pkg::*;
#(
  parameter int OPERAND_WIDTH = branch_types_pkg::OPERAND_WIDTH
) (
  input  logic       clk,
  input  logic       rst,

  // Configuration write port
  input  logic       cfg_we_i,
  input  vec_sel_t   cfg_sel_i,
  input  addr_t      cfg_wdata_i,

  // Exception raised in control stage
  input  logic       exc_raise_i,
  input  exc_cause_e exc_cause_i,

  // Redirect request and its vector
  output logic       exc_redirect_o,
  output addr_t      exc_pc_o
);

  // One slot per cause
  localparam int NUM_VEC = 2 ** $bits(vec_sel_t);

  // Spacing of the reset vectors
  localparam int VEC_STRIDE = 'h100;

  addr_t vec_q [NUM_VEC];

  // Vectors kept word aligned, low bits dropped on write
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_VEC; i++) begin
        vec_q[i] <= OPERAND_WIDTH'(i * VEC_STRIDE);
      end
    end else if (cfg_we_i) begin
      vec_q[cfg_sel_i] <= {cfg_wdata_i[OPERAND_WIDTH-1:2], 2'b00};
    end
  end

  // A raise with no cause is ignored
  assign exc_redirect_o = exc_raise_i & (exc_cause_i != EXC_NONE);

  // Vector lookup straight from the registers
  assign exc_pc_o = vec_q[vec_sel_t'(exc_cause_i)];

endmodule

//--- branch_ctrl.sv
module branch_ctrl
  import branch_types_pkg::*;
#(
  parameter int OPERAND_WIDTH = branch_types_pkg::OPERAND_WIDTH
) (
  input  logic  clk,
  input  logic  rst,

  // Pipeline control
  input  logic  pipeline_flush_i,
  input  logic  padv_decode_i,
  input  logic  decode_bubble_i,

  // Branch info from decode
  input  logic  dec_branch_i,
  input  logic  dec_jr_i,
  input  addr_t dec_target_i,

  // Register operand B, target of a register jump
  input  addr_t ex_rfb_i,

  // Fault and exception inputs
  input  logic  execute_except_align_i,
  input  logic  ctrl_except_syscall_i,
  input  logic  exc_redirect_i,
  input  addr_t exc_pc_i,

  // Redirect to fetch
  output logic  branch_occur_o,
  output addr_t branch_target_o
);

  logic                     imm_branch_q;
  logic [OPERAND_WIDTH-1:0] imm_target_q;
  logic                     op_jr_q;
  logic                     occur_q;
  logic [OPERAND_WIDTH-1:0] target_q;
  logic [OPERAND_WIDTH-1:0] target_new;
  logic                     jr_ok;
  logic                     new_branch;

  // Decode branch moved into execute, in line with register jumps
  always_ff @(posedge clk) begin
    if (rst || pipeline_flush_i) begin
      imm_branch_q <= 1'b0;
      op_jr_q      <= 1'b0;
    end else if (decode_bubble_i) begin
      imm_branch_q <= 1'b0;
      op_jr_q      <= 1'b0;
    end else if (padv_decode_i) begin
      imm_branch_q <= dec_branch_i;
      op_jr_q      <= dec_jr_i;
    end
  end

  // Target follows the branch it belongs to
  always_ff @(posedge clk) begin
    if (padv_decode_i) begin
      imm_target_q <= dec_target_i;
    end
  end

  // Alignment fault only counts in the first jump cycle,
  // later the operand may already have moved on
  assign jr_ok = op_jr_q & ~(execute_except_align_i & ~occur_q);

  // Exceptions first, syscall blocks everything else
  assign branch_occur_o = exc_redirect_i |
                          (~ctrl_except_syscall_i & (imm_branch_q | jr_ok));

  // Target pick, same priority as the strobe
  assign target_new = exc_redirect_i ? exc_pc_i :
                      imm_branch_q   ? imm_target_q :
                                       ex_rfb_i;

  // Previous strobe for edge detection
  always_ff @(posedge clk) begin
    if (rst) begin
      occur_q <= 1'b0;
    end else begin
      occur_q <= branch_occur_o;
    end
  end

  // First cycle of a redirect
  assign new_branch = branch_occur_o & ~occur_q;

  // Hold the target since the jump operand may be gone next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      target_q <= {OPERAND_WIDTH{1'b0}};
    end else if (new_branch) begin
      target_q <= target_new;
    end
  end

  assign branch_target_o = new_branch ? target_new : target_q;

endmodule

//--- branch_unit_top.sv
module branch_unit_top
  import branch_types_pkg::*;
  import branch_isa_pkg::*;
#(
  parameter int OPERAND_WIDTH = branch_types_pkg::OPERAND_WIDTH
) (
  input  logic       clk,
  input  logic       rst,

  // Decode side
  input  insn_t      decode_insn_i,
  input  addr_t      decode_pc_i,
  input  logic       padv_decode_i,
  input  logic       decode_bubble_i,

  // Execute and control side
  input  logic       pipeline_flush_i,
  input  logic       ctrl_flag_i,
  input  addr_t      ex_rfb_i,
  input  logic       execute_except_align_i,
  input  logic       ctrl_except_syscall_i,
  input  logic       exc_raise_i,
  input  exc_cause_e exc_cause_i,

  // Vector configuration
  input  logic       cfg_we_i,
  input  vec_sel_t   cfg_sel_i,
  input  addr_t      cfg_wdata_i,

  // Redirect to fetch
  output logic       branch_occur_o,
  output addr_t      branch_target_o
);

  logic  dec_branch;
  logic  dec_jr;
  addr_t dec_target;
  logic  exc_redirect;
  addr_t exc_pc;

  // Branch kind and immediate target
  branch_decode #(
    .OPERAND_WIDTH(OPERAND_WIDTH)
  ) branch_decode_i (
    .decode_insn_i(decode_insn_i),
    .decode_pc_i  (decode_pc_i),
    .ctrl_flag_i  (ctrl_flag_i),
    .dec_branch_o (dec_branch),
    .dec_jr_o     (dec_jr),
    .dec_target_o (dec_target)
  );

  // Exception vectors
  except_vector_regs #(
    .OPERAND_WIDTH(OPERAND_WIDTH)
  ) except_vector_regs_i (
    .clk           (clk),
    .rst           (rst),
    .cfg_we_i      (cfg_we_i),
    .cfg_sel_i     (cfg_sel_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .exc_raise_i   (exc_raise_i),
    .exc_cause_i   (exc_cause_i),
    .exc_redirect_o(exc_redirect),
    .exc_pc_o      (exc_pc)
  );

  // Redirect resolution
  branch_ctrl #(
    .OPERAND_WIDTH(OPERAND_WIDTH)
  ) branch_ctrl_i (
    .clk                   (clk),
    .rst                   (rst),
    .pipeline_flush_i      (pipeline_flush_i),
    .padv_decode_i         (padv_decode_i),
    .decode_bubble_i       (decode_bubble_i),
    .dec_branch_i          (dec_branch),
    .dec_jr_i              (dec_jr),
    .dec_target_i          (dec_target),
    .ex_rfb_i              (ex_rfb_i),
    .execute_except_align_i(execute_except_align_i),
    .ctrl_except_syscall_i (ctrl_except_syscall_i),
    .exc_redirect_i        (exc_redirect),
    .exc_pc_i              (exc_pc),
    .branch_occur_o        (branch_occur_o),
    .branch_target_o       (branch_target_o)
  );

endmodule

//--- branch_unit_checker.sv
module branch_unit_checker #(
  parameter int OPERAND_WIDTH = 32
) (
  input logic                     clk,
  input logic                     rst,
  input logic                     branch_occur_i,
  input logic [OPERAND_WIDTH-1:0] branch_target_i,
  input logic                     exc_redirect_i,
  input logic [OPERAND_WIDTH-1:0] exc_pc_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions
  int unsigned fail_count = 0;

  // Strobe is quiet in the first cycle out of reset
  assert property (@(posedge clk) $fell(rst) |-> !branch_occur_i)
  else begin
    $error("branch_occur_o is high in the first cycle after reset");
    fail_count++;
  end

  // Held target must not move while the strobe stays up
  assert property (@(posedge clk) disable iff (rst)
    branch_occur_i && $past(branch_occur_i) |-> $stable(branch_target_i))
  else begin
    $error("branch_target_o changed while branch_occur_o stayed high");
    fail_count++;
  end

  // Exception raises the strobe and puts its vector out in the first cycle
  assert property (@(posedge clk) disable iff (rst)
    exc_redirect_i |-> branch_occur_i &&
      ($past(branch_occur_i) || branch_target_i == exc_pc_i))
  else begin
    $error("exception redirect without strobe or with a wrong first-cycle target");
    fail_count++;
  end

endmodule

//--- tb_branch_unit.sv
module tb_branch_unit
  import branch_types_pkg::*;
  import branch_isa_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;

  // One data line with inputs and expected outputs
  typedef struct packed {
    int       line_no;
    insn_t    insn;
    addr_t    pc;
    logic     padv;
    logic     bubble;
    logic     flush;
    logic     flag;
    addr_t    rfb;
    logic     align;
    logic     syscall;
    logic     raise;
    logic [1:0] cause;
    logic     cfg_we;
    vec_sel_t cfg_sel;
    addr_t    cfg_wdata;
    logic     exp_occur;
    logic     check_target;
    addr_t    exp_target;
  } stim_t;

  logic       clk;
  logic       rst;
  insn_t      decode_insn;
  addr_t      decode_pc;
  logic       padv_decode;
  logic       decode_bubble;
  logic       pipeline_flush;
  logic       ctrl_flag;
  addr_t      ex_rfb;
  logic       execute_except_align;
  logic       ctrl_except_syscall;
  logic       exc_raise;
  exc_cause_e exc_cause;
  logic       cfg_we;
  vec_sel_t   cfg_sel;
  addr_t      cfg_wdata;
  logic       branch_occur;
  addr_t      branch_target;

  stim_t       vectors[$];
  int          cycle_count = 0;
  int          cycle_limit = 1000;
  int unsigned bound_fails;

  branch_unit_top #(
    .OPERAND_WIDTH(OPERAND_WIDTH)
  ) branch_unit_top_i (
    .clk                   (clk),
    .rst                   (rst),
    .decode_insn_i         (decode_insn),
    .decode_pc_i           (decode_pc),
    .padv_decode_i         (padv_decode),
    .decode_bubble_i       (decode_bubble),
    .pipeline_flush_i      (pipeline_flush),
    .ctrl_flag_i           (ctrl_flag),
    .ex_rfb_i              (ex_rfb),
    .execute_except_align_i(execute_except_align),
    .ctrl_except_syscall_i (ctrl_except_syscall),
    .exc_raise_i           (exc_raise),
    .exc_cause_i           (exc_cause),
    .cfg_we_i              (cfg_we),
    .cfg_sel_i             (cfg_sel),
    .cfg_wdata_i           (cfg_wdata),
    .branch_occur_o        (branch_occur),
    .branch_target_o       (branch_target)
  );

  // Invariant checks inside branch control
  bind branch_ctrl branch_unit_checker #(
    .OPERAND_WIDTH(OPERAND_WIDTH)
  ) branch_unit_checker_i (
    .clk            (clk),
    .rst            (rst),
    .branch_occur_i (branch_occur_o),
    .branch_target_i(branch_target_o),
    .exc_redirect_i (exc_redirect_i),
    .exc_pc_i       (exc_pc_i)
  );

  assign bound_fails = branch_unit_top_i.branch_ctrl_i.branch_unit_checker_i.fail_count;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic idle_inputs();
    decode_insn          = '0;
    decode_pc            = '0;
    padv_decode          = 1'b0;
    decode_bubble        = 1'b0;
    pipeline_flush       = 1'b0;
    ctrl_flag            = 1'b0;
    ex_rfb               = '0;
    execute_except_align = 1'b0;
    ctrl_except_syscall  = 1'b0;
    exc_raise            = 1'b0;
    exc_cause            = EXC_NONE;
    cfg_we               = 1'b0;
    cfg_sel              = '0;
    cfg_wdata            = '0;
  endtask

  // Whole file parsed up front to size the timeout
  task automatic load_vectors();
    int         fd;
    int         rc;
    int         line_no;
    string      line;
    string      tgt_str;
    stim_t      v;
    insn_t      f_insn;
    addr_t      f_pc;
    addr_t      f_rfb;
    addr_t      f_wdata;
    addr_t      f_tgt;
    logic [1:0] f_cause;
    vec_sel_t   f_sel;
    logic       f_padv;
    logic       f_bub;
    logic       f_flush;
    logic       f_flag;
    logic       f_align;
    logic       f_sys;
    logic       f_raise;
    logic       f_we;
    logic       f_occ;
    fd = $fopen("branch_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open branch_testdata.txt");
    end
    line_no = 0;
    while ($fgets(line, fd) != 0) begin
      line_no++;
      // Comment and empty lines
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      rc = $sscanf(line, "%h %h %b %b %b %b %h %b %b %b %h %b %h %h %b %s",
                   f_insn, f_pc, f_padv, f_bub, f_flush, f_flag, f_rfb, f_align,
                   f_sys, f_raise, f_cause, f_we, f_sel, f_wdata, f_occ, tgt_str);
      if (rc != 16) begin
        abort_run($sformatf("Line %0d of branch_testdata.txt is malformed", line_no));
      end
      v.line_no   = line_no;
      v.insn      = f_insn;
      v.pc        = f_pc;
      v.padv      = f_padv;
      v.bubble    = f_bub;
      v.flush     = f_flush;
      v.flag      = f_flag;
      v.rfb       = f_rfb;
      v.align     = f_align;
      v.syscall   = f_sys;
      v.raise     = f_raise;
      v.cause     = f_cause;
      v.cfg_we    = f_we;
      v.cfg_sel   = f_sel;
      v.cfg_wdata = f_wdata;
      v.exp_occur = f_occ;
      // Dash means target not compared
      if (tgt_str == "-") begin
        v.check_target = 1'b0;
        v.exp_target   = '0;
      end else begin
        rc = $sscanf(tgt_str, "%h", f_tgt);
        if (rc != 1) begin
          abort_run($sformatf("Line %0d of branch_testdata.txt has a bad target", line_no));
        end
        v.check_target = 1'b1;
        v.exp_target   = f_tgt;
      end
      vectors.push_back(v);
    end
    $fclose(fd);
    if (vectors.size() == 0) begin
      abort_run("No test vectors found in branch_testdata.txt");
    end
  endtask

  task automatic apply_vector(input stim_t v);
    decode_insn          = v.insn;
    decode_pc            = v.pc;
    padv_decode          = v.padv;
    decode_bubble        = v.bubble;
    pipeline_flush       = v.flush;
    ctrl_flag            = v.flag;
    ex_rfb               = v.rfb;
    execute_except_align = v.align;
    ctrl_except_syscall  = v.syscall;
    exc_raise            = v.raise;
    exc_cause            = exc_cause_e'(v.cause);
    cfg_we               = v.cfg_we;
    cfg_sel              = v.cfg_sel;
    cfg_wdata            = v.cfg_wdata;
  endtask

  task automatic compare_outputs(input stim_t v);
    assert (branch_occur === v.exp_occur)
    else abort_run($sformatf("[FAIL] time %0t line %0d: branch_occur_o = %0b, expected %0b",
                             $time, v.line_no, branch_occur, v.exp_occur));
    if (v.check_target) begin
      assert (branch_target === v.exp_target)
      else abort_run($sformatf("[FAIL] time %0t line %0d: branch_target_o = %h, expected %h",
                               $time, v.line_no, branch_target, v.exp_target));
    end
  endtask

  // Timeout and bound assertion watch on the falling edge
  always @(negedge clk) begin
    cycle_count++;
    if (bound_fails != 0) begin
      abort_run("A bound assertion in branch_ctrl failed");
    end else if (cycle_count > cycle_limit) begin
      abort_run("Timeout, the test did not finish within the cycle limit");
    end
  end

  initial begin
    rst = 1'b1;
    idle_inputs();
    load_vectors();
    cycle_limit = RESET_CYCLES + vectors.size() + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Drive on the falling edge
    // Compare 1 ns before the rising edge
    foreach (vectors[i]) begin
      @(negedge clk);
      apply_vector(vectors[i]);
      #(CLK_PERIOD / 2 - 1);
      compare_outputs(vectors[i]);
    end
    @(negedge clk);
    idle_inputs();
    // Give the bound assertions the last cycles
    repeat (2) @(posedge clk);
    #1;
    if (bound_fails == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("A bound assertion in branch_ctrl failed");
    end
  end

endmodule

//--- build.f
branch_types_pkg.sv
branch_isa_pkg.sv
branch_decode.sv
except_vector_regs.sv
branch_ctrl.sv
branch_unit_top.sv
branch_unit_checker.sv
tb_branch_unit.sv

//--- Bender.yml
package:
  name: branch_unit

sources:
  # Packages first, the ISA package imports the type package
  - branch_types_pkg.sv
  - branch_isa_pkg.sv
  # Design
  - branch_decode.sv
  - except_vector_regs.sv
  - branch_ctrl.sv
  - branch_unit_top.sv
  # Simulation only
  - target: test
    files:
      - branch_unit_checker.sv
      - tb_branch_unit.sv

//--- branch_testdata.txt
# insn pc padv bubble flush flag rfb align syscall raise cause cfg_we cfg_sel cfg_wdata
# then exp_occur exp_target, a dash in place of exp_target skips the target compare
00000004 00001000 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00000000
54000000 00001004 1 0 0 0 00000000 0 0 0 0 0 0 00000000 1 00001010
10000008 00002000 1 0 0 1 00000000 0 0 0 0 0 0 00000000 0 00001010
54000000 00002004 1 0 0 0 00000000 0 0 0 0 0 0 00000000 1 00002020
0ffffffc 00003000 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00002020
54000000 00003004 1 0 0 0 00000000 0 0 0 0 0 0 00000000 1 00002ff0
10000008 00004000 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00002ff0
54000000 00004004 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00002ff0
00000004 00005000 1 1 0 0 00000000 0 0 0 0 0 0 00000000 0 00002ff0
54000000 00005004 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00002ff0
00000004 00006000 1 0 1 0 00000000 0 0 0 0 0 0 00000000 0 00002ff0
54000000 00006004 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00002ff0
00000004 00007000 0 0 0 0 00000000 0 0 0 0 0 0 00000000 0 -
00000004 00007000 0 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00002ff0
00000004 00007000 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00002ff0
54000000 00007004 1 0 0 0 00000000 0 0 0 0 0 0 00000000 1 00007010
44000000 00008000 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00007010
54000000 00008004 1 0 0 0 0000a000 0 0 0 0 0 0 00000000 1 0000a000
44000000 00008100 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 0000a000
54000000 00008104 1 0 0 0 0000b000 1 0 0 0 0 0 00000000 0 0000a000
54000000 00008108 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 0000a000
54000000 0000810c 1 0 0 0 00000000 0 0 1 2 0 0 00000000 1 00000200
54000000 00008110 1 0 0 0 00000000 0 0 0 0 1 1 00c0ffef 0 00000200
54000000 00008114 1 0 0 0 00000000 0 0 1 1 0 0 00000000 1 00c0ffec
54000000 00008118 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00c0ffec
00000004 00009000 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00c0ffec
54000000 00009004 1 0 0 0 00000000 0 0 1 3 0 0 00000000 1 00000300
54000000 00009008 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00000300
54000000 0000900c 1 0 0 0 00000000 0 0 1 0 0 0 00000000 0 00000300
00000004 0000a000 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00000300
54000000 0000a004 1 0 0 0 00000000 0 1 0 0 0 0 00000000 0 00000300
44000000 0000b000 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00000300
54000000 0000b004 1 0 0 0 0000c000 0 1 0 0 0 0 00000000 0 00000300
44000000 0000c000 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 00000300
54000000 0000c004 0 0 0 0 0000d000 0 0 0 0 0 0 00000000 1 0000d000
54000000 0000c004 0 0 0 0 0000d100 0 0 0 0 0 0 00000000 1 0000d000
54000000 0000c004 0 0 0 0 0000d200 0 0 0 0 0 0 00000000 1 0000d000
54000000 0000c004 1 0 0 0 0000d300 0 0 0 0 0 0 00000000 1 0000d000
54000000 0000c008 1 0 0 0 00000000 0 0 0 0 0 0 00000000 0 0000d000
